//--- src/fw_cfg_pkg.sv
// Pixel config firmware definitions
`default_nettype none

package fw_cfg_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  typedef logic [31:0] word_t;        // Read data and status word
  typedef logic [23:0] payload_t;     // Command payload
  typedef logic [15:0] cfg_word_t;    // One config array word
  typedef logic [6:0]  period_t;      // Fast config clock period
  typedef logic [7:0]  array_addr_t;  // Payload bits 23..16

  localparam int ARRAY_DEPTH = 4;
  localparam int SHIFT_W     = ARRAY_DEPTH * $bits(cfg_word_t);  // Chain length in bits
  localparam int DATA_WORDS  = SHIFT_W / $bits(word_t);          // Readout words

  typedef logic [SHIFT_W-1:0] shift_vec_t;
  typedef logic [6:0]         shift_cnt_t;   // Counts up to SHIFT_W

  // ----------------------------------------------------------
  // Op codes
  // ----------------------------------------------------------
  // Zero is no operation
  typedef logic [2:0] op_code_t;

  localparam op_code_t OP_W_STATIC       = 3'd1;
  localparam op_code_t OP_R_STATIC       = 3'd2;
  localparam op_code_t OP_W_ARRAY        = 3'd3;
  localparam op_code_t OP_R_ARRAY        = 3'd4;
  localparam op_code_t OP_R_DATA         = 3'd5;
  localparam op_code_t OP_W_STATUS_CLEAR = 3'd6;
  localparam op_code_t OP_W_EXECUTE      = 3'd7;

  // Static register fields
  localparam int STATIC_PERIOD_LSB = 0;   // Period in bits 6..0
  localparam int STATIC_SPS_BIT    = 7;   // Super-pixel select

  // Execute payload fields
  localparam int EXEC_DELAY_LSB      = 0;   // 7 bits
  localparam int EXEC_SAMPLE_LSB     = 7;   // 7 bits
  localparam int EXEC_LOOPBACK_BIT   = 18;
  localparam int EXEC_MASK_RESET_BIT = 23;  // Skip the reset_not pulse
  localparam int DELAY_MIN           = 3;

  // Status word
  localparam int STATUS_DONE_BIT  = 12;
  localparam int STATUS_ERROR_BIT = 31;

  // ----------------------------------------------------------
  // Bundles
  // ----------------------------------------------------------
  typedef struct packed {
    op_code_t op;
    payload_t payload;
  } cmd_t;

  // Bit i carries op code i+1
  typedef struct packed {
    logic w_execute;
    logic w_status_clear;
    logic r_data;
    logic r_array;
    logic r_static;
    logic w_array;
    logic w_static;
  } op_strobe_t;

  // Lines to the ASIC
  typedef struct packed {
    logic super_pixel_sel;
    logic config_clk;
    logic reset_not;    // Active low ASIC reset
    logic config_in;    // Serial chain data
    logic config_load;  // Low while shifting
  } dut_ctrl_t;

endpackage

`default_nettype wire

//--- src/cmd_decoder.sv
// Command decoder
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
  input  wire logic              fw_axi_clk,
  input  wire logic              op_code_w_reset,
  input  wire logic              dev_id_enable,   // Level enable for this device
  input  wire logic              cmd_valid,
  output logic                   cmd_ready,
  input  wire fw_cfg_pkg::cmd_t  cmd,
  input  wire logic              busy,            // Execute test running
  input  wire logic              resp_pending,    // Read response not yet taken
  output fw_cfg_pkg::op_strobe_t strobe           // One cycle per accepted op
);

  import fw_cfg_pkg::*;

  op_strobe_t strobe_next;
  logic       accept;

  // Hold the channel while the test runs or a response waits
  assign cmd_ready = !busy && !resp_pending;

  // A disabled device still takes the command, then drops it
  assign accept = cmd_valid && cmd_ready && dev_id_enable;

  always_comb begin
    strobe_next = '0;
    if (accept) begin
      case (cmd.op)
        OP_W_STATIC:       strobe_next.w_static       = 1'b1;
        OP_R_STATIC:       strobe_next.r_static       = 1'b1;
        OP_W_ARRAY:        strobe_next.w_array        = 1'b1;
        OP_R_ARRAY:        strobe_next.r_array        = 1'b1;
        OP_R_DATA:         strobe_next.r_data         = 1'b1;
        OP_W_STATUS_CLEAR: strobe_next.w_status_clear = 1'b1;
        OP_W_EXECUTE:      strobe_next.w_execute      = 1'b1;
        default:           strobe_next                = '0;  // No operation
      endcase
    end
  end

  // Strobe shows in the cycle after the transfer
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      strobe <= '0;
    end else begin
      strobe <= strobe_next;
    end
  end

  a_strobe_onehot : assert property (
    @(posedge fw_axi_clk) disable iff (op_code_w_reset) $onehot0(strobe)
  ) else $error("More than one op strobe active");

endmodule

`default_nettype wire

//--- src/config_regs.sv
// Static config register and config array
`timescale 1ns/1ps
`default_nettype none

module config_regs (
  input  wire logic                  fw_axi_clk,
  input  wire logic                  op_code_w_reset,
  input  wire fw_cfg_pkg::op_strobe_t strobe,
  input  wire fw_cfg_pkg::payload_t  payload,
  output fw_cfg_pkg::payload_t       static_reg,
  output fw_cfg_pkg::shift_vec_t     array_words,     // Word 0 in the LSBs
  output fw_cfg_pkg::period_t        period,          // Fast config clock period
  output logic                       super_pixel_sel
);

  import fw_cfg_pkg::*;

  cfg_word_t [ARRAY_DEPTH-1:0] array_q;
  array_addr_t                 addr;

  assign addr = payload[$bits(payload_t)-1 -: $bits(array_addr_t)];

  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      static_reg <= '0;
      array_q    <= '0;
    end else begin
      if (strobe.w_static) begin
        static_reg <= payload;
      end
      // Addresses past the array are dropped
      if (strobe.w_array && (addr < ARRAY_DEPTH)) begin
        array_q[addr[$clog2(ARRAY_DEPTH)-1:0]] <= payload[$bits(cfg_word_t)-1:0];
      end
    end
  end

  // ----------------------------------------------------------
  // Field extraction
  // ----------------------------------------------------------
  assign array_words     = array_q;
  assign period          = static_reg[STATIC_PERIOD_LSB +: $bits(period_t)];
  assign super_pixel_sel = static_reg[STATIC_SPS_BIT];

endmodule

`default_nettype wire

//--- src/config_clk_gen.sv
// Fast config clock generator
`timescale 1ns/1ps
`default_nettype none

module config_clk_gen (
  input  wire logic                fw_axi_clk,
  input  wire logic                op_code_w_reset,
  input  wire fw_cfg_pkg::period_t period,        // Counter wraps after this value
  output fw_cfg_pkg::period_t      clk_counter,
  output logic                     config_clk
);

  // Free running, restarts when the period shrinks below the count
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      clk_counter <= '0;
    end else if (clk_counter >= period) begin
      clk_counter <= '0;                          // Wrap
    end else begin
      clk_counter <= clk_counter + 1'b1;
    end
  end

  // High over the upper half of the count
  assign config_clk = (clk_counter > (period >> 1));

endmodule

`default_nettype wire

//--- src/serial_config_test.sv
// Serial config chain execute test
`timescale 1ns/1ps
`default_nettype none

module serial_config_test (
  input  wire logic                   fw_axi_clk,
  input  wire logic                   op_code_w_reset,
  input  wire fw_cfg_pkg::op_strobe_t strobe,
  input  wire fw_cfg_pkg::payload_t   payload,
  input  wire fw_cfg_pkg::period_t    period,
  input  wire fw_cfg_pkg::period_t    clk_counter,
  input  wire logic                   config_clk,      // From the clock generator
  input  wire logic                   super_pixel_sel,
  input  wire fw_cfg_pkg::shift_vec_t array_words,
  input  wire logic                   config_out,      // Chain output from the ASIC
  output fw_cfg_pkg::dut_ctrl_t       dut,
  output fw_cfg_pkg::shift_vec_t      captured,        // Readout register
  output logic                        busy,
  output logic                        done,
  output logic                        error            // Bad execute config
);

  import fw_cfg_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    RESET_PULSE,   // reset_not low for a counter cycle
    WAIT_SAMPLE,   // Bit on config_in, wait for sample point
    WAIT_DELAY,    // Wait for shift point
    DONE
  } state_t;

  state_t     state;
  period_t    delay_q;
  period_t    sample_q;
  logic       loopback_q;
  logic       mask_q;
  logic       wrapped_q;     // Counter has passed zero in RESET_PULSE
  shift_vec_t chain_q;
  shift_cnt_t shift_cnt;     // Captures so far

  period_t    exec_delay;
  logic       cfg_bad;
  logic       start;
  logic       launch;
  logic       shifting;
  logic       sample_hit;
  logic       delay_hit;
  logic       capture_bit;

  assign exec_delay  = payload[EXEC_DELAY_LSB +: $bits(period_t)];
  assign cfg_bad     = (exec_delay < DELAY_MIN) || (exec_delay > period);
  assign start       = (state == IDLE) && strobe.w_execute;
  assign launch      = start && !cfg_bad;
  assign shifting    = (state == WAIT_SAMPLE) || (state == WAIT_DELAY);
  assign sample_hit  = (state == WAIT_SAMPLE) && (clk_counter == sample_q);
  assign delay_hit   = (state == WAIT_DELAY) && (clk_counter == delay_q);
  assign capture_bit = loopback_q ? chain_q[0] : config_out;  // Loopback takes own config_in

  // ----------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      state     <= IDLE;
      done      <= 1'b0;
      error     <= 1'b0;
      wrapped_q <= 1'b0;
      shift_cnt <= '0;
    end else begin
      if (strobe.w_status_clear) begin
        done  <= 1'b0;
        error <= 1'b0;
      end
      case (state)
        IDLE: begin
          if (start) begin
            done  <= 1'b0;
            error <= cfg_bad;           // Bad delay stays idle
            if (!cfg_bad) begin
              state     <= RESET_PULSE;
              wrapped_q <= 1'b0;
              shift_cnt <= '0;
            end
          end
        end
        RESET_PULSE: begin
          if (clk_counter == '0) begin
            wrapped_q <= 1'b1;
          end
          if (wrapped_q && (clk_counter == period)) begin
            state <= WAIT_SAMPLE;       // Full counter cycle seen
          end
        end
        WAIT_SAMPLE: begin
          if (sample_hit) begin
            shift_cnt <= shift_cnt + 1'b1;
            state     <= (shift_cnt == SHIFT_W - 1) ? DONE : WAIT_DELAY;
          end
        end
        WAIT_DELAY: begin
          if (delay_hit) begin
            state <= WAIT_SAMPLE;
          end
        end
        DONE: begin
          done  <= 1'b1;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Chain and capture datapath
  // ----------------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (start) begin
      delay_q    <= exec_delay;
      sample_q   <= payload[EXEC_SAMPLE_LSB +: $bits(period_t)];
      loopback_q <= payload[EXEC_LOOPBACK_BIT];
      mask_q     <= payload[EXEC_MASK_RESET_BIT];
    end
    if (launch) begin
      chain_q  <= array_words;
      captured <= '0;
    end else begin
      if (sample_hit) begin
        captured <= {capture_bit, captured[SHIFT_W-1:1]};  // New bit enters MSB
      end
      if (delay_hit) begin
        chain_q <= {1'b0, chain_q[SHIFT_W-1:1]};
      end
    end
  end

  assign busy = (state != IDLE);

  // Idle levels when no test runs
  always_comb begin
    dut.super_pixel_sel = busy && super_pixel_sel;
    dut.config_clk      = busy && config_clk;
    dut.reset_not       = !((state == RESET_PULSE) && !mask_q);
    dut.config_in       = shifting && chain_q[0];
    dut.config_load     = !busy;
  end

  a_shift_cnt_max : assert property (
    @(posedge fw_axi_clk) disable iff (op_code_w_reset) shift_cnt <= SHIFT_W
  ) else $error("Shift count beyond chain length");

endmodule

`default_nettype wire

//--- src/readback_status.sv
// Read response and status word
`timescale 1ns/1ps
`default_nettype none

module readback_status (
  input  wire logic                   fw_axi_clk,
  input  wire logic                   op_code_w_reset,
  input  wire fw_cfg_pkg::op_strobe_t strobe,
  input  wire fw_cfg_pkg::payload_t   payload,
  input  wire fw_cfg_pkg::payload_t   static_reg,
  input  wire fw_cfg_pkg::shift_vec_t array_words,
  input  wire fw_cfg_pkg::shift_vec_t captured,
  input  wire logic                   done,
  input  wire logic                   error,
  output logic                        rd_valid,
  input  wire logic                   rd_ready,
  output fw_cfg_pkg::word_t           rd_data,
  output logic                        resp_pending,   // Blocks new commands
  output fw_cfg_pkg::word_t           status
);

  import fw_cfg_pkg::*;

  cfg_word_t [ARRAY_DEPTH-1:0] words;
  word_t [DATA_WORDS-1:0]      data_words;
  array_addr_t                 addr;
  logic                        rd_strobe;
  word_t                       rd_next;

  // Zero outside the array, 9 bits so addr+1 cannot wrap
  function automatic cfg_word_t word_at(input cfg_word_t [ARRAY_DEPTH-1:0] w,
                                        input logic [8:0] idx);
    word_at = (idx < ARRAY_DEPTH) ? w[idx[$clog2(ARRAY_DEPTH)-1:0]] : '0;
  endfunction

  assign words        = array_words;
  assign data_words   = captured;        // Word 0 is the first captured bits
  assign addr         = payload[$bits(payload_t)-1 -: $bits(array_addr_t)];
  assign rd_strobe    = strobe.r_static || strobe.r_array || strobe.r_data;
  assign resp_pending = rd_valid || rd_strobe;

  always_comb begin
    rd_next = '0;
    if (strobe.r_static) begin
      rd_next = word_t'(static_reg);                  // Zero-extended
    end else if (strobe.r_array) begin
      rd_next = {word_at(words, {1'b0, addr} + 9'd1), word_at(words, {1'b0, addr})};
    end else if (strobe.r_data && (addr < DATA_WORDS)) begin
      rd_next = data_words[addr[$clog2(DATA_WORDS)-1:0]];
    end
  end

  // ----------------------------------------------------------
  // Read channel
  // ----------------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      rd_valid <= 1'b0;
    end else if (rd_strobe) begin
      rd_valid <= 1'b1;
    end else if (rd_ready) begin
      rd_valid <= 1'b0;                               // Taken by the reader
    end
  end

  always_ff @(posedge fw_axi_clk) begin
    if (rd_strobe) begin
      rd_data <= rd_next;
    end
  end

  // Sticky op bits at their op code index
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset || strobe.w_status_clear) begin
      status <= '0;
    end else begin
      status[OP_W_EXECUTE:OP_W_STATIC] <= status[OP_W_EXECUTE:OP_W_STATIC] | strobe;
      status[STATUS_DONE_BIT]          <= done;
      status[STATUS_ERROR_BIT]         <= error;
    end
  end

  a_rd_hold : assert property (
    @(posedge fw_axi_clk) disable iff (op_code_w_reset)
    rd_valid && !rd_ready |=> rd_valid && $stable(rd_data)
  ) else $error("Read response changed before it was taken");

endmodule

`default_nettype wire

//--- src/fw_ip_top.sv
// Pixel config firmware top
`timescale 1ns/1ps
`default_nettype none

module fw_ip_top (
  input  wire logic             fw_axi_clk,
  input  wire logic             op_code_w_reset,
  input  wire logic             dev_id_enable,
  // Command channel
  input  wire logic             cmd_valid,
  output logic                  cmd_ready,
  input  wire fw_cfg_pkg::cmd_t cmd,
  // Read channel and status
  output logic                  rd_valid,
  input  wire logic             rd_ready,
  output fw_cfg_pkg::word_t     rd_data,
  output fw_cfg_pkg::word_t     status,
  // ASIC side
  output fw_cfg_pkg::dut_ctrl_t dut,
  input  wire logic             config_out
);

  import fw_cfg_pkg::*;

  op_strobe_t strobe;
  logic       busy;
  logic       resp_pending;
  payload_t   static_reg;
  shift_vec_t array_words;
  shift_vec_t captured;
  period_t    period;
  period_t    clk_counter;
  logic       super_pixel_sel;
  logic       config_clk;
  logic       done;
  logic       error;

  // Input side
  cmd_decoder u_cmd_decoder (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .dev_id_enable   (dev_id_enable),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd             (cmd),
    .busy            (busy),
    .resp_pending    (resp_pending),
    .strobe          (strobe)
  );

  // Payload is read straight off the channel in the strobe cycle
  config_regs u_config_regs (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .strobe          (strobe),
    .payload         (cmd.payload),
    .static_reg      (static_reg),
    .array_words     (array_words),
    .period          (period),
    .super_pixel_sel (super_pixel_sel)
  );

  config_clk_gen u_config_clk_gen (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .period          (period),
    .clk_counter     (clk_counter),
    .config_clk      (config_clk)
  );

  serial_config_test u_serial_config_test (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .strobe          (strobe),
    .payload         (cmd.payload),
    .period          (period),
    .clk_counter     (clk_counter),
    .config_clk      (config_clk),
    .super_pixel_sel (super_pixel_sel),
    .array_words     (array_words),
    .config_out      (config_out),
    .dut             (dut),
    .captured        (captured),
    .busy            (busy),
    .done            (done),
    .error           (error)
  );

  // Output side
  readback_status u_readback_status (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .strobe          (strobe),
    .payload         (cmd.payload),
    .static_reg      (static_reg),
    .array_words     (array_words),
    .captured        (captured),
    .done            (done),
    .error           (error),
    .rd_valid        (rd_valid),
    .rd_ready        (rd_ready),
    .rd_data         (rd_data),
    .resp_pending    (resp_pending),
    .status          (status)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 2,   // 4 ns clock
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Held over the first rising edges, dropped on a falling edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/tb_top.sv
// Pixel config firmware testbench
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  import fw_cfg_pkg::*;

  localparam int         READY_TIMEOUT = 50;     // Cycles for a handshake
  localparam int         TEST_TIMEOUT  = 4000;   // Cycles for a full chain test
  localparam logic [4:0] IDLE_DUT      = 5'b00101;  // sps, clk, reset_not, config_in, load

  logic      clk;
  logic      rst;
  logic      dev_id_enable;
  logic      cmd_valid;
  logic      cmd_ready;
  cmd_t      cmd;
  logic      rd_valid;
  logic      rd_ready;
  word_t     rd_data;
  word_t     status;
  dut_ctrl_t dut;
  logic      config_out;

  logic                        invert_mode;   // ASIC model inverts config_in
  logic                        exp_sps;       // Static bit 7 as last written
  logic                        no_reset;      // reset_not must stay high
  logic                        ready_hold;    // cmd_ready must stay high
  logic                        chk_req;
  string                       chk_name;
  word_t                       chk_exp;
  word_t                       chk_act;
  logic [15:0]                 lfsr_state;
  cfg_word_t [ARRAY_DEPTH-1:0] arr;           // Model of the config array
  int                          reset_low_cycles = 0;
  int                          load_low_cycles  = 0;
  int                          clk_high_cycles  = 0;

  tb_clk_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  fw_ip_top u_dut (
    .fw_axi_clk      (clk),
    .op_code_w_reset (rst),
    .dev_id_enable   (dev_id_enable),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd             (cmd),
    .rd_valid        (rd_valid),
    .rd_ready        (rd_ready),
    .rd_data         (rd_data),
    .status          (status),
    .dut             (dut),
    .config_out      (config_out)
  );

  // ASIC chain model, loopback ignores it
  assign config_out = invert_mode ? !dut.config_in : dut.config_in;

  always @(posedge clk) begin
    if (!dut.reset_not) reset_low_cycles <= reset_low_cycles + 1;
    if (!dut.config_load) load_low_cycles <= load_low_cycles + 1;
    if (dut.config_clk) clk_high_cycles <= clk_high_cycles + 1;
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  a_check : assert property (@(posedge clk) chk_req |-> chk_act == chk_exp)
    else end_with_failure($sformatf("ERROR %s expected %h actual %h",
                                    chk_name, chk_exp, chk_act));
  a_idle_levels : assert property (@(posedge clk) disable iff (rst)
    dut.config_load |-> dut == IDLE_DUT)
    else end_with_failure($sformatf("ERROR idle_levels expected %b actual %b",
                                    IDLE_DUT, $sampled(dut)));
  a_sps : assert property (@(posedge clk) disable iff (rst)
    !dut.config_load |-> dut.super_pixel_sel == exp_sps)
    else end_with_failure($sformatf("ERROR super_pixel_sel expected %0b actual %0b",
                                    exp_sps, $sampled(dut.super_pixel_sel)));
  a_no_reset : assert property (@(posedge clk) no_reset |-> dut.reset_not)
    else end_with_failure("ERROR reset_mask expected 1 actual 0");
  a_ready_hold : assert property (@(posedge clk) ready_hold |-> cmd_ready)
    else end_with_failure("ERROR bad_config_ready expected 1 actual 0");

  task automatic end_with_failure(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "Stopped at the first failure");
  endtask

  // Value held for one rising edge, seen there by a_check
  task automatic check_value(input string name, input word_t exp, input word_t act);
    chk_name = name;
    chk_exp  = exp;
    chk_act  = act;
    chk_req  = 1'b1;
    @(negedge clk);
    chk_req  = 1'b0;
  endtask

  task automatic check_status(input string name, input word_t exp);
    @(negedge clk);            // Let the last status update land
    check_value(name, exp, status);
  endtask

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};   // One step per bit
    end
  endtask

  // ----------------------------------------------------------
  // Command and read channel
  // ----------------------------------------------------------
  task automatic send_cmd(input op_code_t op, input payload_t pl);
    int waited;
    @(negedge clk);
    waited = 0;
    while (!cmd_ready && waited < READY_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!cmd_ready) end_with_failure("cmd_ready stayed low, a command could not be sent");
    cmd_valid   = 1'b1;
    cmd.op      = op;
    cmd.payload = pl;            // Kept until the next command
    @(negedge clk);              // Transfer on the edge in between
    cmd_valid   = 1'b0;
  endtask

  task automatic expect_read(input string name, input op_code_t op,
                             input array_addr_t addr, input word_t exp);
    int          waited;
    logic [31:0] hold;
    word_t       got;
    send_cmd(op, {addr, 16'h0000});
    waited = 0;
    while (!rd_valid && waited < READY_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!rd_valid) end_with_failure("No read response arrived");
    take_bits(2, hold);
    repeat (hold[1:0]) @(negedge clk);   // Random back-pressure
    got      = rd_data;
    rd_ready = 1'b1;
    @(negedge clk);
    rd_ready = 1'b0;
    check_value(name, exp, got);
  endtask

  task automatic wait_status_bit(input int idx, input int limit, input string what);
    int waited;
    waited = 0;
    while (!status[idx] && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (!status[idx]) end_with_failure(what);
  endtask

  // Delay 5, sample 2, with the period at 9
  task automatic run_execute(input string name, input logic loopback, input logic mask);
    payload_t pl;
    int       resets_before;
    int       loads_before;
    int       clks_before;
    int       waited;
    pl = '0;
    pl[EXEC_DELAY_LSB +: 7]  = 7'd5;
    pl[EXEC_SAMPLE_LSB +: 7] = 7'd2;
    pl[EXEC_LOOPBACK_BIT]    = loopback;
    pl[EXEC_MASK_RESET_BIT]  = mask;
    send_cmd(OP_W_STATUS_CLEAR, '0);   // Old done bit gone
    resets_before = reset_low_cycles;
    loads_before  = load_low_cycles;
    clks_before   = clk_high_cycles;
    no_reset      = mask;
    send_cmd(OP_W_EXECUTE, pl);
    wait_status_bit(STATUS_DONE_BIT, TEST_TIMEOUT, "Done bit never rose after execute");
    waited = 0;
    while (!cmd_ready && waited < READY_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!cmd_ready) end_with_failure("cmd_ready did not return after the test");
    no_reset = 1'b0;
    check_value({name, "_reset_pulse"}, word_t'(!mask), word_t'(reset_low_cycles > resets_before));
    check_value({name, "_load_low"}, 32'd1, word_t'(load_low_cycles > loads_before));
    check_value({name, "_config_clk"}, 32'd1, word_t'(clk_high_cycles > clks_before));
    check_status({name, "_status"}, 32'h0000_1080);   // Execute op and done
  endtask

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  initial begin
    word_t       static_val;
    logic [31:0] bits;
    cfg_word_t   upper;
    int          waited;
    dev_id_enable = 1'b1;
    cmd_valid     = 1'b0;
    cmd           = '0;
    rd_ready      = 1'b0;
    invert_mode   = 1'b0;
    exp_sps       = 1'b0;
    no_reset      = 1'b0;
    ready_hold    = 1'b0;
    chk_req       = 1'b0;
    chk_name      = "";
    chk_exp       = '0;
    chk_act       = '0;
    lfsr_state    = 16'd34;
    @(negedge clk);
    waited = 0;
    while (rst && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (rst) end_with_failure("Reset was never released");
    check_value("reset_handshake", 32'd2, {cmd_ready, rd_valid});
    check_value("reset_status", '0, status);

    // Static register round trip
    take_bits(24, bits);
    send_cmd(OP_W_STATIC, bits[23:0]);
    expect_read("static_read", OP_R_STATIC, 8'd0, bits);

    // Array words and pair reads
    for (int i = 0; i < ARRAY_DEPTH; i++) begin
      take_bits(16, bits);
      arr[i] = bits[15:0];
      send_cmd(OP_W_ARRAY, {8'(i), bits[15:0]});
    end
    for (int i = 0; i < ARRAY_DEPTH; i++) begin
      upper = '0;
      if (i < ARRAY_DEPTH - 1) upper = arr[i + 1];   // Zero past the end
      expect_read($sformatf("array_read_%0d", i), OP_R_ARRAY, 8'(i), {upper, arr[i]});
    end
    expect_read("array_read_9", OP_R_ARRAY, 8'd9, '0);

    // Sticky op bits, clear, disabled device
    check_status("status_ops", 32'h0000_001e);
    send_cmd(OP_W_STATUS_CLEAR, '0);
    check_status("status_clear", '0);
    dev_id_enable = 1'b0;
    send_cmd(OP_W_ARRAY, {8'd0, ~arr[0]});
    check_status("status_disabled", '0);
    dev_id_enable = 1'b1;
    expect_read("array_unchanged", OP_R_ARRAY, 8'd0, {arr[1], arr[0]});

    // Loopback test, period 9
    take_bits(24, bits);
    static_val      = bits;
    static_val[6:0] = 7'd9;
    exp_sps         = static_val[STATIC_SPS_BIT];
    send_cmd(OP_W_STATIC, static_val[23:0]);
    invert_mode = 1'b1;   // Return path inverted, only loopback gives the array back
    run_execute("loopback", 1'b1, 1'b0);
    expect_read("loopback_data_0", OP_R_DATA, 8'd0, {arr[1], arr[0]});
    expect_read("loopback_data_1", OP_R_DATA, 8'd1, {arr[3], arr[2]});
    expect_read("data_out_of_range", OP_R_DATA, 8'd2, '0);

    // ASIC path with inverted return, reset masked
    run_execute("inverted", 1'b0, 1'b1);
    expect_read("inverted_data_0", OP_R_DATA, 8'd0, ~{arr[1], arr[0]});
    expect_read("inverted_data_1", OP_R_DATA, 8'd1, ~{arr[3], arr[2]});

    // Delay 1 is below the minimum
    send_cmd(OP_W_STATUS_CLEAR, '0);
    ready_hold = 1'b1;
    send_cmd(OP_W_EXECUTE, 24'd1 | (24'd2 << EXEC_SAMPLE_LSB));
    wait_status_bit(STATUS_ERROR_BIT, READY_TIMEOUT, "Error bit never rose on a bad delay");
    check_status("bad_config_status", 32'h8000_0080);
    check_value("bad_config_dut", word_t'(IDLE_DUT), word_t'(dut));
    ready_hold = 1'b0;

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
src/fw_cfg_pkg.sv
src/cmd_decoder.sv
src/config_regs.sv
src/config_clk_gen.sv
src/serial_config_test.sv
src/readback_status.sv
src/fw_ip_top.sv
testbench/tb_clk_gen.sv
testbench/tb_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim &&
  ./obj_dir/tb_sim || exit 1
